/* compile.f */
logic/tmds_pkg.sv
logic/video_timing.sv
logic/pattern_regs.sv
logic/tmds_encoder.sv
logic/serializer.sv
logic/hdmi_tx.sv
tests/tb_clock.sv
tests/tb_hdmi_tx.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     = --binary --timing
TOP       = tb_hdmi_tx
FILES     = compile.f
PASS      = Done: no errors

SOURCES := $(shell cat $(FILES))
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILES) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILES)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf obj_dir

/* tests/tb_hdmi_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_hdmi_tx
    import tmds_pkg::*;
;

    localparam int h_active = 16;
    localparam int h_front  = 2;
    localparam int h_sync   = 4;
    localparam int h_back   = 2;
    localparam int v_active = 4;
    localparam int v_front  = 1;
    localparam int v_sync   = 2;
    localparam int v_back   = 1;
    localparam int h_total  = h_active + h_front + h_sync + h_back;
    localparam int v_total  = v_active + v_front + v_sync + v_back;
    localparam int cycle_limit = 4 * h_total * v_total + 2000;
    localparam int rounds      = 4;
    localparam int write_guard = 12; // Pixel cycles from a write to its first serial word, padded.

    logic       clk_pixel;
    logic       clk_pixel_x5;
    logic       rst;
    axil_req_t  axi_req;
    axil_rsp_t  axi_rsp;
    logic [2:0] tmds;
    logic       tmds_clock;

    int   seed;
    int   cycle_count      = 0;
    int   last_write_cycle = -1000;
    rgb_t model_color      = '0;
    logic model_mode       = 1'b0;

    // Monitor state, owned by the deserializer process.
    tmds_word_t rx [4];
    logic       locked         = 1'b0;
    logic       aligned        = 1'b0;
    int         bit_count      = 0;
    int         h              = 0;
    int         v              = 0;
    int         frames_seen    = 0;
    int         pixels_checked = 0;
    int         disparity [3]  = '{0, 0, 0};
    rgb_t       line_color;
    logic       line_mode;
    logic       line_checked;
    int         line_start_cycle;

    tb_clock i_clock (.clk_pixel(clk_pixel), .clk_pixel_x5(clk_pixel_x5), .rst(rst));

    hdmi_tx #(
        .h_active(h_active), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
        .v_active(v_active), .v_front(v_front), .v_sync(v_sync), .v_back(v_back)
    ) i_hdmi_tx (
        .clk_pixel(clk_pixel), .clk_pixel_x5(clk_pixel_x5), .rst(rst),
        .axi_req(axi_req), .axi_rsp(axi_rsp), .tmds(tmds), .tmds_clock(tmds_clock)
    );

    //////////////////////////////////////////////////
    // Reporting and compare tasks.
    //////////////////////////////////////////////////

    task automatic stop_run();
        $display("Done: errors found");
        $fatal(1, "Run stopped");
    endtask

    task automatic report_mismatch(input string msg);
        $display("Fail at %0.1f ns: %s", $realtime, msg);
        stop_run();
    endtask

    task automatic check_rsp(input axil_rsp_t got, input axil_rsp_t exp, input axil_rsp_t mask,
                             input string what);
        if ((got & mask) !== (exp & mask))
            report_mismatch($sformatf("%s: response %h, expected %h", what, got & mask,
                                      exp & mask));
    endtask

    task automatic check_word(input tmds_word_t got, input tmds_word_t exp, input string what);
        if (got !== exp)
            report_mismatch($sformatf("%s: word %b, expected %b", what, got, exp));
    endtask

    task automatic check_pixel(input rgb_t got, input rgb_t exp, input string what);
        if (got !== exp)
            report_mismatch($sformatf("%s: pixel %h, expected %h", what, got, exp));
    endtask

    //////////////////////////////////////////////////
    // TMDS reference model.
    //////////////////////////////////////////////////

    task automatic encode_symbol(input logic [7:0] d, inout int cnt, output tmds_word_t w);
        logic [8:0] qm;
        logic       xnor_sel;
        int         n1d;
        int         n1q;
        int         n0q;
        n1d      = $countones(d);
        xnor_sel = (n1d > 4) || (n1d == 4 && d[0] == 1'b0);
        qm[0]    = d[0];
        for (int i = 1; i < 8; i++)
            qm[i] = xnor_sel ? (qm[i-1] ~^ d[i]) : (qm[i-1] ^ d[i]);
        qm[8] = ~xnor_sel;
        n1q   = $countones(qm[7:0]);
        n0q   = 8 - n1q;
        if (cnt == 0 || n1q == n0q)
        begin
            w   = {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
            cnt = qm[8] ? cnt + n1q - n0q : cnt + n0q - n1q;
        end
        else if ((cnt > 0 && n1q > n0q) || (cnt < 0 && n0q > n1q))
        begin
            w   = {1'b1, qm[8], ~qm[7:0]};
            cnt = cnt + (qm[8] ? 2 : 0) + n0q - n1q;
        end
        else
        begin
            w   = {1'b0, qm[8], qm[7:0]};
            cnt = cnt - (qm[8] ? 0 : 2) + n1q - n0q;
        end
    endtask

    function automatic logic [7:0] decode_symbol(input tmds_word_t w);
        logic [7:0] d;
        logic [7:0] q;
        d    = w[9] ? ~w[7:0] : w[7:0];
        q[0] = d[0];
        for (int i = 1; i < 8; i++)
            q[i] = w[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);
        return q;
    endfunction

    //////////////////////////////////////////////////
    // Deserializer and stream checks.
    //////////////////////////////////////////////////

    task automatic check_video_word();
        logic       de;
        logic       hs;
        logic       vs;
        logic [7:0] dec [3];
        tmds_word_t exp_w;
        rgb_t       got_px;
        rgb_t       exp_px;
        if (h == 0)
        begin
            line_color       = model_color;
            line_mode        = model_mode;
            line_start_cycle = cycle_count;
            line_checked     = (cycle_count - last_write_cycle) >= write_guard;
        end
        de = (h < h_active) && (v < v_active);
        hs = (h >= h_active + h_front) && (h < h_active + h_front + h_sync);
        vs = (v >= v_active + v_front) && (v < v_active + v_front + v_sync);
        if (de)
        begin
            for (int i = 0; i < 3; i++)
            begin
                dec[i] = decode_symbol(rx[i]);
                encode_symbol(dec[i], disparity[i], exp_w);
                check_word(rx[i], exp_w, $sformatf("lane %0d active symbol", i));
                if (disparity[i] > 10 || disparity[i] < -10)
                    report_mismatch($sformatf("lane %0d disparity %0d out of range", i,
                                              disparity[i]));
            end
            if (last_write_cycle >= line_start_cycle)
                line_checked = 1'b0; // A write landed inside this line.
            got_px.red   = dec[2];
            got_px.green = dec[1];
            got_px.blue  = dec[0];
            if (line_mode)
            begin
                exp_px.red   = 8'(h);
                exp_px.green = 8'(h);
                exp_px.blue  = 8'(h);
            end
            else
                exp_px = line_color;
            if (line_checked)
            begin
                check_pixel(got_px, exp_px, $sformatf("pixel x %0d y %0d", h, v));
                pixels_checked = pixels_checked + 1;
            end
        end
        else
        begin
            check_word(rx[0], ctrl_code[{vs, hs}], "blue control symbol");
            check_word(rx[1], ctrl_code[0], "green control symbol");
            check_word(rx[2], ctrl_code[0], "red control symbol");
            for (int i = 0; i < 3; i++)
                disparity[i] = 0;
        end
        h = h + 1;
        if (h == h_total)
        begin
            h = 0;
            v = (v == v_total - 1) ? 0 : v + 1;
            if (v == 0)
                frames_seen = frames_seen + 1;
        end
    endtask

    task automatic process_word();
        check_word(rx[3], clock_pattern, "clock lane");
        if (!aligned && rx[0] === ctrl_code[0])
        begin
            // Idle before the first frame starts.
            for (int i = 1; i < 3; i++)
                check_word(rx[i], ctrl_code[0], $sformatf("lane %0d before first frame", i));
        end
        else
        begin
            aligned = 1'b1;
            check_video_word();
        end
    endtask

    // Each half of the fast clock carries one bit, LSB first.
    always @(clk_pixel_x5)
    begin
        #0.5;
        for (int i = 0; i < 3; i++)
            rx[i] = {tmds[i], rx[i][9:1]};
        rx[3] = {tmds_clock, rx[3][9:1]};
        if (!locked)
        begin
            if (rx[3] === clock_pattern)
            begin
                locked    = 1'b1;
                bit_count = 0;
                process_word();
            end
        end
        else
        begin
            bit_count = bit_count + 1;
            if (bit_count == 10)
            begin
                bit_count = 0;
                process_word();
            end
        end
    end

    //////////////////////////////////////////////////
    // AXI4-Lite master.
    //////////////////////////////////////////////////

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        int          stall;
        logic [23:0] merged;
        axil_rsp_t   exp;
        axil_rsp_t   mask;
        stall      = $random(seed) & 3;
        exp        = '0;
        exp.bvalid = 1'b1;
        mask       = '0;
        mask.awready = 1'b1;
        mask.wready  = 1'b1;
        mask.bvalid  = 1'b1;
        mask.bresp   = '1;
        @(posedge clk_pixel);
        axi_req.awaddr  <= addr;
        axi_req.awvalid <= 1'b1;
        axi_req.wdata   <= data;
        axi_req.wstrb   <= strb;
        axi_req.wvalid  <= 1'b1;
        @(posedge clk_pixel);
        while (!(axi_rsp.awready && axi_rsp.wready))
            @(posedge clk_pixel);
        axi_req.awvalid <= 1'b0;
        axi_req.wvalid  <= 1'b0;
        merged = model_color;
        for (int b = 0; b < 3; b++)
        begin
            if (strb[b])
                merged[8*b +: 8] = data[8*b +: 8];
        end
        if (addr == reg_color_addr)
        begin
            model_color      = merged;
            last_write_cycle = cycle_count;
        end
        else if (addr == reg_mode_addr)
        begin
            if (strb[0])
                model_mode = data[0];
            last_write_cycle = cycle_count;
        end
        @(posedge clk_pixel);
        while (!axi_rsp.bvalid)
            @(posedge clk_pixel);
        repeat (stall)
        begin
            check_rsp(axi_rsp, exp, mask, "write response held under stall");
            @(posedge clk_pixel);
        end
        check_rsp(axi_rsp, exp, mask, "write response");
        axi_req.bready <= 1'b1;
        @(posedge clk_pixel);
        check_rsp(axi_rsp, exp, mask, "write response handshake");
        axi_req.bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, input logic [31:0] value);
        int        stall;
        axil_rsp_t exp;
        axil_rsp_t mask;
        stall      = $random(seed) & 3;
        exp        = '0;
        exp.rvalid = 1'b1;
        exp.rdata  = value;
        mask         = '0;
        mask.arready = 1'b1;
        mask.rvalid  = 1'b1;
        mask.rdata   = '1;
        mask.rresp   = '1;
        @(posedge clk_pixel);
        axi_req.araddr  <= addr;
        axi_req.arvalid <= 1'b1;
        @(posedge clk_pixel);
        while (!axi_rsp.arready)
            @(posedge clk_pixel);
        axi_req.arvalid <= 1'b0;
        @(posedge clk_pixel);
        while (!axi_rsp.rvalid)
            @(posedge clk_pixel);
        repeat (stall)
        begin
            check_rsp(axi_rsp, exp, mask, $sformatf("read %h held under stall", addr));
            @(posedge clk_pixel);
        end
        axi_req.rready <= 1'b1;
        @(posedge clk_pixel);
        check_rsp(axi_rsp, exp, mask, $sformatf("read %h handshake", addr));
        axi_req.rready <= 1'b0;
    endtask

    function automatic logic [3:0] unknown_addr();
        logic [3:0] a;
        a = 4'($random(seed));
        if (a == reg_color_addr || a == reg_mode_addr)
            a = 4'h8;
        return a;
    endfunction

    always @(posedge clk_pixel)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("Timeout: the run did not finish within %0d pixel cycles", cycle_limit);
            stop_run();
        end
    end

    initial
    begin
        logic [31:0] data;
        logic [3:0]  strb;
        int          target;
        seed    = 31;
        axi_req = '0;
        wait (!rst);
        @(posedge clk_pixel);
        for (int round = 0; round < rounds; round++)
        begin
            data = $random(seed);
            strb = 4'($random(seed));
            axi_write(reg_color_addr, data, strb);
            data = $random(seed);
            strb = 4'($random(seed));
            axi_write(reg_mode_addr, data, strb);
            data = $random(seed);
            axi_write(unknown_addr(), data, 4'hf); // Must leave both registers alone.
            axi_read(reg_color_addr, {8'h00, model_color});
            axi_read(reg_mode_addr, {31'h0, model_mode});
            axi_read(unknown_addr(), 32'h0);
            target = frames_seen + 1;
            while (frames_seen < target)
                @(posedge clk_pixel);
        end
        if (pixels_checked > 0)
        begin
            $display("Done: no errors");
            $finish;
        end
        else
        begin
            $display("The monitor checked no pixels");
            stop_run();
        end
    end

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock
(
    output logic clk_pixel,
    output logic clk_pixel_x5,
    output logic rst
);

    initial
    begin
        clk_pixel = 1'b0;
        forever #5 clk_pixel = ~clk_pixel;
    end

    // Five fast periods per pixel, so the rising edges line up.
    initial
    begin
        clk_pixel_x5 = 1'b0;
        forever #1 clk_pixel_x5 = ~clk_pixel_x5;
    end

    initial
    begin
        rst = 1'b1;
        repeat (8) @(posedge clk_pixel);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* logic/hdmi_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module hdmi_tx
    import tmds_pkg::*;
#(
    parameter int h_active = 16,
    parameter int h_front  = 2,
    parameter int h_sync   = 4,
    parameter int h_back   = 2,
    parameter int v_active = 4,
    parameter int v_front  = 1,
    parameter int v_sync   = 2,
    parameter int v_back   = 1
)
(
    input  logic       clk_pixel,
    input  logic       clk_pixel_x5,
    input  logic       rst,
    input  axil_req_t  axi_req,
    output axil_rsp_t  axi_rsp,
    output logic [2:0] tmds,
    output logic       tmds_clock
);

    video_ctrl_t timing_ctrl;
    video_ctrl_t pixel_ctrl;
    logic [7:0]  x;
    rgb_t        pixel;
    tmds_word_t  sym_blue;
    tmds_word_t  sym_green;
    tmds_word_t  sym_red;
    tmds_lanes_t lanes;

    video_timing #(
        .h_active(h_active), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
        .v_active(v_active), .v_front(v_front), .v_sync(v_sync), .v_back(v_back)
    ) i_timing (
        .clk_pixel(clk_pixel), .rst(rst), .ctrl(timing_ctrl), .x(x)
    );

    pattern_regs i_regs (
        .clk_pixel(clk_pixel), .rst(rst), .axi_req(axi_req), .axi_rsp(axi_rsp),
        .ctrl_in(timing_ctrl), .x(x), .ctrl_out(pixel_ctrl), .pixel(pixel)
    );

    // Sync bits ride on the blue channel only.
    tmds_encoder i_enc_blue (
        .clk_pixel(clk_pixel), .rst(rst), .de(pixel_ctrl.de),
        .ctrl({pixel_ctrl.vsync, pixel_ctrl.hsync}), .data(pixel.blue), .symbol(sym_blue)
    );

    tmds_encoder i_enc_green (
        .clk_pixel(clk_pixel), .rst(rst), .de(pixel_ctrl.de),
        .ctrl(2'b00), .data(pixel.green), .symbol(sym_green)
    );

    tmds_encoder i_enc_red (
        .clk_pixel(clk_pixel), .rst(rst), .de(pixel_ctrl.de),
        .ctrl(2'b00), .data(pixel.red), .symbol(sym_red)
    );

    assign lanes = {sym_red, sym_green, sym_blue};

    serializer i_serializer (
        .clk_pixel(clk_pixel), .clk_pixel_x5(clk_pixel_x5), .rst(rst),
        .lanes(lanes), .tmds(tmds), .tmds_clock(tmds_clock)
    );

endmodule

`default_nettype wire

/* logic/serializer.sv */
`timescale 1ns/1ps
`default_nettype none

module serializer
    import tmds_pkg::*;
(
    input  logic        clk_pixel,
    input  logic        clk_pixel_x5,
    input  logic        rst,
    input  tmds_lanes_t lanes,
    output logic [2:0]  tmds,
    output logic        tmds_clock
);

    tmds_lanes_t lanes_hold;
    logic        rst_x5;
    logic [2:0]  phase;
    logic [9:0]  shift [4];
    logic [3:0]  ddr_bit;

    // Parallel word register in the pixel domain.
    always_ff @(posedge clk_pixel)
    begin
        lanes_hold <= lanes;
    end

    always_ff @(posedge clk_pixel_x5)
    begin
        rst_x5 <= rst;
    end

    //////////////////////////////////////////////////
    // Fast domain, five bit pairs per pixel.
    //////////////////////////////////////////////////

    always_ff @(posedge clk_pixel_x5)
    begin
        if (rst_x5)
        begin
            phase <= '0;
            for (int i = 0; i < 4; i++)
                shift[i] <= '0;
        end
        else
        begin
            phase <= (phase == 3'd4) ? 3'd0 : phase + 3'd1;
            if (phase == 3'd4)
            begin
                for (int i = 0; i < 3; i++)
                    shift[i] <= lanes_hold[i];
                shift[3] <= clock_pattern; // Clock lane.
            end
            else
            begin
                for (int i = 0; i < 4; i++)
                    shift[i] <= shift[i] >> 2;
            end
        end
    end

    // Low bit in the high half of the fast clock, next bit in the low half.
    for (genvar i = 0; i < 4; i++)
    begin : g_ddr
        assign ddr_bit[i] = clk_pixel_x5 ? shift[i][0] : shift[i][1];
    end

    assign tmds       = ddr_bit[2:0];
    assign tmds_clock = ddr_bit[3];

endmodule

`default_nettype wire

/* logic/tmds_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

module tmds_encoder
    import tmds_pkg::*;
(
    input  logic       clk_pixel,
    input  logic       rst,
    input  logic       de,
    input  logic [1:0] ctrl,
    input  logic [7:0] data,
    output tmds_word_t symbol
);

    logic [8:0]        q_m;
    logic [3:0]        ones_q;
    logic signed [5:0] balance;
    logic signed [5:0] disparity;
    logic signed [5:0] disparity_next;
    tmds_word_t        word;

    // Transition minimizing stage, bit 8 set when XOR was used.
    function automatic logic [8:0] minimize(input logic [7:0] d);
        logic [3:0] ones;
        logic       use_xnor;
        logic [8:0] q;
        ones     = 4'($countones(d));
        use_xnor = (ones > 4'd4) || (ones == 4'd4 && !d[0]);
        q[0]     = d[0];
        for (int i = 1; i < 8; i++)
        begin
            q[i] = use_xnor ? ~(q[i-1] ^ d[i]) : (q[i-1] ^ d[i]);
        end
        q[8] = !use_xnor;
        return q;
    endfunction

    assign q_m     = minimize(data);
    assign ones_q  = 4'($countones(q_m[7:0]));
    assign balance = $signed({1'b0, ones_q, 1'b0}) - 6'sd8; // Ones minus zeros.

    always_comb
    begin
        word[8] = q_m[8];
        if (disparity == 6'sd0 || balance == 6'sd0)
        begin
            word[9]        = ~q_m[8];
            word[7:0]      = q_m[8] ? q_m[7:0] : ~q_m[7:0];
            disparity_next = q_m[8] ? disparity + balance : disparity - balance;
        end
        else if ((disparity > 6'sd0 && balance > 6'sd0) ||
                 (disparity < 6'sd0 && balance < 6'sd0))
        begin
            // Inverting pulls the running disparity back toward zero.
            word[9]        = 1'b1;
            word[7:0]      = ~q_m[7:0];
            disparity_next = disparity - balance + (q_m[8] ? 6'sd2 : 6'sd0);
        end
        else
        begin
            word[9]        = 1'b0;
            word[7:0]      = q_m[7:0];
            disparity_next = disparity + balance - (q_m[8] ? 6'sd0 : 6'sd2);
        end
    end

    always_ff @(posedge clk_pixel)
    begin
        if (rst)
        begin
            symbol    <= ctrl_code[0];
            disparity <= '0;
        end
        else if (de)
        begin
            symbol    <= word;
            disparity <= disparity_next;
        end
        else
        begin
            symbol    <= ctrl_code[ctrl];
            disparity <= '0; // Blanking restarts the balance.
        end
    end

endmodule

`default_nettype wire

/* logic/pattern_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module pattern_regs
    import tmds_pkg::*;
(
    input  logic        clk_pixel,
    input  logic        rst,
    input  axil_req_t   axi_req,
    output axil_rsp_t   axi_rsp,
    input  video_ctrl_t ctrl_in,
    input  logic [7:0]  x,
    output video_ctrl_t ctrl_out,
    output rgb_t        pixel
);

    typedef enum logic [1:0] {w_idle, w_accept, w_resp} w_state_t;
    typedef enum logic [1:0] {r_idle, r_accept, r_resp} r_state_t;

    w_state_t    w_state;
    r_state_t    r_state;
    rgb_t        color;
    logic        mode;
    logic [31:0] color_merged;
    logic [31:0] mode_merged;
    logic [31:0] read_value;
    logic [31:0] rdata;

    function automatic logic [31:0] byte_merge(input logic [31:0] old_value,
                                               input logic [31:0] new_value,
                                               input logic [3:0]  strobe);
        logic [31:0] merged;
        merged = old_value;
        for (int i = 0; i < 4; i++)
        begin
            if (strobe[i])
                merged[8*i +: 8] = new_value[8*i +: 8];
        end
        return merged;
    endfunction

    //////////////////////////////////////////////////
    // Write channel.
    //////////////////////////////////////////////////

    assign color_merged = byte_merge({8'h00, color}, axi_req.wdata, axi_req.wstrb);
    assign mode_merged  = byte_merge({31'h0, mode}, axi_req.wdata, axi_req.wstrb);

    always_ff @(posedge clk_pixel)
    begin
        if (rst)
            w_state <= w_idle;
        else
        begin
            case (w_state)
                w_idle:   if (axi_req.awvalid && axi_req.wvalid) w_state <= w_accept;
                w_accept: w_state <= w_resp; // Address and data beats complete here.
                default:  if (axi_req.bready) w_state <= w_idle;
            endcase
        end
    end

    always_ff @(posedge clk_pixel)
    begin
        if (rst)
        begin
            color <= '0;
            mode  <= 1'b0;
        end
        else if (w_state == w_accept)
        begin
            if (axi_req.awaddr == reg_color_addr)
                color <= color_merged[23:0];
            else if (axi_req.awaddr == reg_mode_addr)
                mode <= mode_merged[0];
        end
    end

    //////////////////////////////////////////////////
    // Read channel.
    //////////////////////////////////////////////////

    always_comb
    begin
        case (axi_req.araddr)
            reg_color_addr: read_value = {8'h00, color};
            reg_mode_addr:  read_value = {31'h0, mode};
            default:        read_value = '0;
        endcase
    end

    always_ff @(posedge clk_pixel)
    begin
        if (rst)
            r_state <= r_idle;
        else
        begin
            case (r_state)
                r_idle:   if (axi_req.arvalid) r_state <= r_accept;
                r_accept: r_state <= r_resp;
                default:  if (axi_req.rready) r_state <= r_idle;
            endcase
        end
    end

    always_ff @(posedge clk_pixel)
    begin
        if (r_state == r_accept)
            rdata <= read_value;
    end

    always_comb
    begin
        axi_rsp         = '0;
        axi_rsp.awready = (w_state == w_accept);
        axi_rsp.wready  = (w_state == w_accept);
        axi_rsp.bvalid  = (w_state == w_resp);
        axi_rsp.bresp   = 2'b00;
        axi_rsp.arready = (r_state == r_accept);
        axi_rsp.rvalid  = (r_state == r_resp);
        axi_rsp.rdata   = rdata;
        axi_rsp.rresp   = 2'b00;
    end

    //////////////////////////////////////////////////
    // Pixel generator.
    //////////////////////////////////////////////////

    always_ff @(posedge clk_pixel)
    begin
        if (rst)
            ctrl_out <= '0;
        else
            ctrl_out <= ctrl_in; // Keeps timing in step with the pixel.
    end

    always_ff @(posedge clk_pixel)
    begin
        if (!ctrl_in.de)
            pixel <= '0;
        else if (mode)
            pixel <= '{red: x, green: x, blue: x};
        else
            pixel <= color;
    end

endmodule

`default_nettype wire

/* logic/video_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module video_timing
    import tmds_pkg::*;
#(
    parameter int h_active = 16,
    parameter int h_front  = 2,
    parameter int h_sync   = 4,
    parameter int h_back   = 2,
    parameter int v_active = 4,
    parameter int v_front  = 1,
    parameter int v_sync   = 2,
    parameter int v_back   = 1
)
(
    input  logic        clk_pixel,
    input  logic        rst,
    output video_ctrl_t ctrl,
    output logic [7:0]  x
);

    localparam int h_total  = h_active + h_front + h_sync + h_back;
    localparam int v_total  = v_active + v_front + v_sync + v_back;
    localparam int hs_start = h_active + h_front;
    localparam int vs_start = v_active + v_front;
    localparam int hw       = $clog2(h_total);
    localparam int vw       = $clog2(v_total);

    logic [hw-1:0] hcount;
    logic [vw-1:0] vcount;

    always_ff @(posedge clk_pixel)
    begin
        if (rst)
        begin
            hcount <= '0;
            vcount <= '0;
        end
        else if (hcount == hw'(h_total - 1))
        begin
            hcount <= '0;
            // The frame ends on the last line's wrap.
            vcount <= (vcount == vw'(v_total - 1)) ? '0 : vcount + 1'b1;
        end
        else
        begin
            hcount <= hcount + 1'b1;
        end
    end

    always_ff @(posedge clk_pixel)
    begin
        if (rst)
        begin
            ctrl <= '0;
            x    <= '0;
        end
        else
        begin
            ctrl.de    <= (hcount < hw'(h_active)) && (vcount < vw'(v_active));
            ctrl.hsync <= (hcount >= hw'(hs_start)) && (hcount < hw'(hs_start + h_sync));
            ctrl.vsync <= (vcount >= vw'(vs_start)) && (vcount < vw'(vs_start + v_sync));
            x          <= (hcount < hw'(h_active)) ? 8'(hcount) : 8'd0; // Column in the active area.
        end
    end

endmodule

`default_nettype wire

/* logic/tmds_pkg.sv */
`default_nettype none

package tmds_pkg;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
    } video_ctrl_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    typedef logic [9:0] tmds_word_t;
    typedef tmds_word_t [2:0] tmds_lanes_t; // Lane 0 is blue.

    //////////////////////////////////////////////////
    // AXI4-Lite channels.
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [3:0]  awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [3:0]  araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

    // Control symbols, indexed by {c1, c0}.
    localparam tmds_word_t ctrl_code [4] = '{
        10'b1101010100,
        10'b0010101011,
        10'b0101010100,
        10'b1010101011
    };

    localparam tmds_word_t clock_pattern = 10'b0000011111;

    localparam logic [3:0] reg_color_addr = 4'h0;
    localparam logic [3:0] reg_mode_addr  = 4'h4;

endpackage

`default_nettype wire
